/* src/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    parameter int data_w     = 32;
    parameter int reg_addr_w = 5;

    typedef logic [data_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        SH_SLL,
        SH_SRL,
        SH_SRA
    } shift_op_t;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_SHIFT,
        RES_MOVZ,
        RES_MOVN
    } res_sel_t;

    // Decoded instruction, one per cycle
    typedef struct packed {
        logic      valid;
        alu_op_t   alu_op;
        shift_op_t shift_op;
        res_sel_t  res_sel;
        logic      b_imm;      // B operand is imm
        logic      shamt_var;  // shift amount from rs
        logic [4:0] shamt;
        word_t     imm;        // already extended
        reg_addr_t rs_addr;
        reg_addr_t rt_addr;
        reg_addr_t rd_addr;
        logic      reg_w;
        logic      of_trap;    // signed overflow cancels the write
    } issue_t;

    // One pipeline register entry
    typedef struct packed {
        logic      reg_w;
        reg_addr_t rd_addr;
        word_t     result;
    } stage_t;

endpackage

`default_nettype wire

/* src/gpr.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr #(
    parameter int reg_count = 32
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  exec_pkg::reg_addr_t  rs_addr,
    input  exec_pkg::reg_addr_t  rt_addr,
    input  exec_pkg::reg_addr_t  wr_addr,
    input  exec_pkg::reg_addr_t  dbg_addr,
    input  wire                  wr_en,
    input  exec_pkg::word_t      wr_data,
    output exec_pkg::word_t      rs_data,
    output exec_pkg::word_t      rt_data,
    output exec_pkg::word_t      dbg_data
);

    // Only the low address bits select a register
    localparam int idx_w = $clog2(reg_count);

    exec_pkg::word_t regs [reg_count];

    // Register 0 is cleared on reset and never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr[idx_w-1:0] != '0)) begin
            regs[wr_addr[idx_w-1:0]] <= wr_data;
        end
    end

    assign rs_data  = regs[rs_addr[idx_w-1:0]];
    assign rt_data  = regs[rt_addr[idx_w-1:0]];
    assign dbg_data = regs[dbg_addr[idx_w-1:0]];

endmodule

`default_nettype wire

/* src/forward_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
    input  exec_pkg::reg_addr_t rs_addr,
    input  exec_pkg::reg_addr_t rt_addr,
    input  exec_pkg::word_t     rs_data,
    input  exec_pkg::word_t     rt_data,
    input  exec_pkg::stage_t    ex_mem,
    input  exec_pkg::stage_t    mem_wb,
    output exec_pkg::word_t     op_a,
    output exec_pkg::word_t     op_b
);

    // A stage can forward only a real write to a nonzero register
    function automatic logic hits(
        input exec_pkg::stage_t    stg,
        input exec_pkg::reg_addr_t addr
    );
        return stg.reg_w && (stg.rd_addr != '0) && (stg.rd_addr == addr);
    endfunction

    // Youngest producer first
    function automatic exec_pkg::word_t pick(
        input exec_pkg::reg_addr_t addr,
        input exec_pkg::word_t     reg_val
    );
        if (hits(ex_mem, addr)) begin
            return ex_mem.result;
        end else if (hits(mem_wb, addr)) begin
            return mem_wb.result;
        end
        return reg_val;
    endfunction

    assign op_a = pick(rs_addr, rs_data);
    assign op_b = pick(rt_addr, rt_data);

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    input  exec_pkg::alu_op_t op,
    output exec_pkg::word_t   result,
    output logic              overflow
);

    localparam int msb  = exec_pkg::data_w - 1;
    localparam int half = exec_pkg::data_w / 2;

    exec_pkg::word_t sum;
    exec_pkg::word_t diff;
    logic            add_of;
    logic            sub_of;

    assign sum  = a + b;
    assign diff = a - b;

    // Signed wrap: operand signs agree (add) or differ (sub)
    // and the result sign flips
    assign add_of = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
    assign sub_of = (a[msb] != b[msb]) && (diff[msb] != a[msb]);

    always_comb begin
        result   = '0;
        overflow = 1'b0;
        case (op)
            exec_pkg::ALU_ADD: begin
                result   = sum;
                overflow = add_of;
            end
            exec_pkg::ALU_ADDU: result = sum;
            exec_pkg::ALU_SUB: begin
                result   = diff;
                overflow = sub_of;
            end
            exec_pkg::ALU_SUBU: result = diff;
            exec_pkg::ALU_AND:  result = a & b;
            exec_pkg::ALU_OR:   result = a | b;
            exec_pkg::ALU_XOR:  result = a ^ b;
            exec_pkg::ALU_NOR:  result = ~(a | b);
            exec_pkg::ALU_SLT: begin
                result = exec_pkg::word_t'($signed(a) < $signed(b));
            end
            exec_pkg::ALU_SLTU: begin
                result = exec_pkg::word_t'(a < b);
            end
            // Low half of B into the upper half
            exec_pkg::ALU_LUI: begin
                result = {b[half-1:0], {half{1'b0}}};
            end
            default: begin
                result   = '0;
                overflow = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  exec_pkg::issue_t issue,
    input  exec_pkg::word_t  op_a,
    input  exec_pkg::word_t  op_b,
    output exec_pkg::stage_t ex_out
);

    exec_pkg::word_t alu_b;
    exec_pkg::word_t alu_res;
    logic            alu_of;
    logic [4:0]      sh_amt;
    exec_pkg::word_t shift_res;
    exec_pkg::word_t ex_res;
    logic            cond_ok;
    logic            of_kill;

    ////////////////////
    // Operand selection
    ////////////////////

    assign alu_b  = issue.b_imm ? issue.imm : op_b;

    // Variable shifts take the amount from rs
    assign sh_amt = issue.shamt_var ? op_a[4:0] : issue.shamt;

    alu u_alu (
        .a        ( op_a         ),
        .b        ( alu_b        ),
        .op       ( issue.alu_op ),
        .result   ( alu_res      ),
        .overflow ( alu_of       )
    );

    ////////////////////
    // Shifter
    ////////////////////

    always_comb begin
        case (issue.shift_op)
            exec_pkg::SH_SLL: shift_res = op_b << sh_amt;
            exec_pkg::SH_SRL: shift_res = op_b >> sh_amt;
            exec_pkg::SH_SRA: shift_res = $signed(op_b) >>> sh_amt;
            default:          shift_res = op_b;
        endcase
    end

    ////////////////////
    // Result and write enable
    ////////////////////

    always_comb begin
        case (issue.res_sel)
            exec_pkg::RES_ALU:   ex_res = alu_res;
            exec_pkg::RES_SHIFT: ex_res = shift_res;
            // movz and movn pass rs through
            default:             ex_res = op_a;
        endcase
    end

    // rt is the move condition
    always_comb begin
        case (issue.res_sel)
            exec_pkg::RES_MOVZ: cond_ok = (op_b == '0);
            exec_pkg::RES_MOVN: cond_ok = (op_b != '0);
            default:            cond_ok = 1'b1;
        endcase
    end

    // Signed add/sub overflow cancels the write when trapping is on
    assign of_kill = issue.of_trap && alu_of;

    always_comb begin
        ex_out.reg_w   = issue.reg_w && cond_ok && !of_kill;
        ex_out.rd_addr = issue.rd_addr;
        ex_out.result  = ex_res;
    end

endmodule

`default_nettype wire

/* src/exec_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_pipeline #(
    parameter int reg_count = 32
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  exec_pkg::issue_t    issue,
    input  wire                 stall,
    input  exec_pkg::reg_addr_t dbg_addr,
    output exec_pkg::stage_t    commit,
    output logic                commit_en,
    output exec_pkg::word_t     dbg_data
);

    exec_pkg::word_t  rs_val;
    exec_pkg::word_t  rt_val;
    exec_pkg::word_t  op_a;
    exec_pkg::word_t  op_b;
    exec_pkg::stage_t ex_out;
    exec_pkg::stage_t ex_mem;
    exec_pkg::stage_t mem_wb;

    // Pipeline register fields
    logic                ex_mem_w;
    exec_pkg::reg_addr_t ex_mem_rd;
    exec_pkg::word_t     ex_mem_res;
    logic                mem_wb_w;
    exec_pkg::reg_addr_t mem_wb_rd;
    exec_pkg::word_t     mem_wb_res;

    gpr #(
        .reg_count ( reg_count )
    ) u_gpr (
        .clk      ( clk            ),
        .rst_n    ( rst_n          ),
        .rs_addr  ( issue.rs_addr  ),
        .rt_addr  ( issue.rt_addr  ),
        .wr_addr  ( commit.rd_addr ),
        .dbg_addr ( dbg_addr       ),
        .wr_en    ( commit_en      ),
        .wr_data  ( commit.result  ),
        .rs_data  ( rs_val         ),
        .rt_data  ( rt_val         ),
        .dbg_data ( dbg_data       )
    );

    forward_unit u_fwd (
        .rs_addr ( issue.rs_addr ),
        .rt_addr ( issue.rt_addr ),
        .rs_data ( rs_val        ),
        .rt_data ( rt_val        ),
        .ex_mem  ( ex_mem        ),
        .mem_wb  ( mem_wb        ),
        .op_a    ( op_a          ),
        .op_b    ( op_b          )
    );

    execute_stage u_ex (
        .issue  ( issue  ),
        .op_a   ( op_a   ),
        .op_b   ( op_b   ),
        .ex_out ( ex_out )
    );

    ////////////////////
    // EX/MEM and MEM/WB
    ////////////////////

    // An idle cycle inserts a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_w <= 1'b0;
            mem_wb_w <= 1'b0;
        end else if (!stall) begin
            ex_mem_w <= issue.valid && ex_out.reg_w;
            mem_wb_w <= ex_mem_w;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (issue.valid) begin
                ex_mem_rd  <= ex_out.rd_addr;
                ex_mem_res <= ex_out.result;
            end
            mem_wb_rd  <= ex_mem_rd;
            mem_wb_res <= ex_mem_res;
        end
    end

    assign ex_mem = '{reg_w: ex_mem_w, rd_addr: ex_mem_rd, result: ex_mem_res};
    assign mem_wb = '{reg_w: mem_wb_w, rd_addr: mem_wb_rd, result: mem_wb_res};

    // Writeback
    assign commit    = mem_wb;
    assign commit_en = mem_wb.reg_w && !stall;

endmodule

`default_nettype wire

/* tb/exec_pipeline_props.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_pipeline_props (
    input wire                 clk,
    input wire                 rst_n,
    input wire                 stall,
    input wire                 commit_en,
    input exec_pkg::stage_t    commit,
    input exec_pkg::reg_addr_t dbg_addr,
    input exec_pkg::word_t     dbg_data
);

    // No writeback while reset is held
    commit_en_in_reset: assert property (
        @(posedge clk) !rst_n |-> !commit_en
    ) else $error("commit_en high during reset");

    // MEM/WB holds across a stalled edge
    commit_held_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n) stall |=> $stable(commit)
    ) else $error("commit changed across a stalled edge");

    // Register 0 always reads zero
    reg_zero_reads_zero: assert property (
        @(posedge clk) (dbg_addr == '0) |-> (dbg_data == '0)
    ) else $error("dbg_data nonzero for register 0");

endmodule

bind exec_pipeline exec_pipeline_props u_props (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .stall     ( stall     ),
    .commit_en ( commit_en ),
    .commit    ( commit    ),
    .dbg_addr  ( dbg_addr  ),
    .dbg_data  ( dbg_data  )
);

`default_nettype wire

/* tb/tb_exec_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_pipeline;

    localparam int clk_period      = 20;
    localparam int num_tests       = 5;
    localparam int max_test_cycles = 300;
    localparam int timeout_cycles  = num_tests * max_test_cycles + 500;

    logic                clk;
    logic                rst_n;
    exec_pkg::issue_t    issue;
    logic                stall;
    exec_pkg::reg_addr_t dbg_addr;
    exec_pkg::stage_t    commit;
    logic                commit_en;
    exec_pkg::word_t     dbg_data;

    // Reference register file, updated in issue order
    exec_pkg::word_t model [32];
    // Writes still to come out of MEM/WB, oldest first
    exec_pkg::stage_t wb_expect [$];
    int              seed;
    int              errors;
    int              tests;
    int              mark;
    logic            stall_mode;

    exec_pipeline #(
        .reg_count ( 32 )
    ) DUT (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .issue     ( issue     ),
        .stall     ( stall     ),
        .dbg_addr  ( dbg_addr  ),
        .commit    ( commit    ),
        .commit_en ( commit_en ),
        .dbg_data  ( dbg_data  )
    );

    always #(clk_period / 2) clk = ~clk;

    ////////////////////
    // Reference model
    ////////////////////

    function automatic void model_exec(input exec_pkg::issue_t ins);
        exec_pkg::word_t  a;
        exec_pkg::word_t  b;
        exec_pkg::word_t  bb;
        exec_pkg::word_t  r;
        logic [32:0]      wide;
        logic [4:0]       amt;
        logic             ovf;
        logic             wr;
        exec_pkg::stage_t wb;
        a    = model[ins.rs_addr];
        b    = model[ins.rt_addr];
        bb   = ins.b_imm ? ins.imm : b;
        amt  = ins.shamt_var ? a[4:0] : ins.shamt;
        ovf  = 1'b0;
        wr   = ins.reg_w;
        r    = '0;
        wide = '0;
        case (ins.res_sel)
            exec_pkg::RES_ALU: begin
                case (ins.alu_op)
                    exec_pkg::ALU_ADD, exec_pkg::ALU_ADDU: begin
                        // Sign-extended sum, overflow when the top two bits differ
                        wide = {a[31], a} + {bb[31], bb};
                        r    = wide[31:0];
                        ovf  = (ins.alu_op == exec_pkg::ALU_ADD) && (wide[32] != wide[31]);
                    end
                    exec_pkg::ALU_SUB, exec_pkg::ALU_SUBU: begin
                        wide = {a[31], a} - {bb[31], bb};
                        r    = wide[31:0];
                        ovf  = (ins.alu_op == exec_pkg::ALU_SUB) && (wide[32] != wide[31]);
                    end
                    exec_pkg::ALU_AND:  r = a & bb;
                    exec_pkg::ALU_OR:   r = a | bb;
                    exec_pkg::ALU_XOR:  r = a ^ bb;
                    exec_pkg::ALU_NOR:  r = ~(a | bb);
                    exec_pkg::ALU_SLT:  r = {31'b0, $signed(a) < $signed(bb)};
                    exec_pkg::ALU_SLTU: r = {31'b0, a < bb};
                    exec_pkg::ALU_LUI:  r = bb << 16;
                    default:            r = '0;
                endcase
            end
            exec_pkg::RES_SHIFT: begin
                case (ins.shift_op)
                    exec_pkg::SH_SLL: r = b << amt;
                    exec_pkg::SH_SRL: r = b >> amt;
                    // Logical shift, then fill the vacated top bits with the sign
                    exec_pkg::SH_SRA: r = (b >> amt) | (b[31] ? ~(32'hffff_ffff >> amt) : 32'h0);
                    default:          r = b;
                endcase
            end
            exec_pkg::RES_MOVZ: begin
                r  = a;
                wr = wr && (b == '0);
            end
            exec_pkg::RES_MOVN: begin
                r  = a;
                wr = wr && (b != '0);
            end
        endcase
        if (ins.of_trap && ovf) begin
            wr = 1'b0;
        end
        // A write to r0 still reaches commit, the register file drops it
        if (wr) begin
            wb.reg_w   = 1'b1;
            wb.rd_addr = ins.rd_addr;
            wb.result  = r;
            wb_expect.push_back(wb);
        end
        if (wr && (ins.rd_addr != '0)) begin
            model[ins.rd_addr] = r;
        end
    endfunction

    ////////////////////
    // Stimulus helpers
    ////////////////////

    function automatic exec_pkg::issue_t base_instr(
        input exec_pkg::reg_addr_t rs,
        input exec_pkg::reg_addr_t rt,
        input exec_pkg::reg_addr_t rd
    );
        exec_pkg::issue_t ins;
        ins         = '0;
        ins.valid   = 1'b1;
        ins.reg_w   = 1'b1;
        ins.rs_addr = rs;
        ins.rt_addr = rt;
        ins.rd_addr = rd;
        return ins;
    endfunction

    // Re-present the instruction until an unstalled edge takes it
    task automatic send(input exec_pkg::issue_t ins);
        logic held;
        held = 1'b1;
        while (held) begin
            issue = ins;
            stall = stall_mode && ($random(seed) % 3 == 0);
            held  = stall;
            @(posedge clk);
            #2;
        end
        model_exec(ins);
        issue = '0;
        stall = 1'b0;
    endtask

    task automatic do_alu(
        input exec_pkg::alu_op_t   op,
        input exec_pkg::reg_addr_t rs,
        input exec_pkg::reg_addr_t rt,
        input exec_pkg::reg_addr_t rd,
        input exec_pkg::word_t     imm,
        input logic                b_imm,
        input logic                trap
    );
        exec_pkg::issue_t ins;
        ins         = base_instr(rs, rt, rd);
        ins.alu_op  = op;
        ins.imm     = imm;
        ins.b_imm   = b_imm;
        ins.of_trap = trap;
        send(ins);
    endtask

    task automatic do_shift(
        input exec_pkg::shift_op_t op,
        input exec_pkg::reg_addr_t rs,
        input exec_pkg::reg_addr_t rt,
        input exec_pkg::reg_addr_t rd,
        input logic [4:0]          amt,
        input logic                var_amt
    );
        exec_pkg::issue_t ins;
        ins           = base_instr(rs, rt, rd);
        ins.res_sel   = exec_pkg::RES_SHIFT;
        ins.shift_op  = op;
        ins.shamt     = amt;
        ins.shamt_var = var_amt;
        send(ins);
    endtask

    task automatic do_move(
        input exec_pkg::res_sel_t  sel,
        input exec_pkg::reg_addr_t rs,
        input exec_pkg::reg_addr_t rt,
        input exec_pkg::reg_addr_t rd
    );
        exec_pkg::issue_t ins;
        ins         = base_instr(rs, rt, rd);
        ins.res_sel = sel;
        send(ins);
    endtask

    // rd = r0 + value
    task automatic load_reg(input exec_pkg::reg_addr_t rd, input exec_pkg::word_t value);
        do_alu(exec_pkg::ALU_ADDU, 5'd0, 5'd0, rd, value, 1'b1, 1'b0);
    endtask

    // Drain the pipeline, then compare every register with the model
    task automatic end_test(input string name);
        repeat (3) @(posedge clk);
        #2;
        if (wb_expect.size() != 0) begin
            errors++;
            $display("%s: %0d expected writebacks never appeared on commit",
                     name, wb_expect.size());
            wb_expect.delete();
        end
        for (int i = 0; i < 32; i++) begin
            dbg_addr = exec_pkg::reg_addr_t'(i);
            @(negedge clk);
            if (dbg_data !== model[i]) begin
                errors++;
                $display("ERR %s r%0d dbg_data expected %h actual %h",
                         name, i, model[i], dbg_data);
            end
            @(posedge clk);
            #2;
        end
        tests++;
        $display("test %-10s %s", name, (errors == mark) ? "ok" : "FAILED");
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_alu();
        exec_pkg::alu_op_t op;
        exec_pkg::word_t   imm;
        mark = errors;
        load_reg(5'd1, $random(seed));
        load_reg(5'd2, $random(seed));
        for (int k = 0; k < 11; k++) begin
            op  = exec_pkg::alu_op_t'(k);
            imm = $random(seed);
            do_alu(op, 5'd1, 5'd2, exec_pkg::reg_addr_t'(3 + k), '0, 1'b0, 1'b0);
            do_alu(op, 5'd1, 5'd0, exec_pkg::reg_addr_t'(14 + k), imm, 1'b1, 1'b0);
        end
        end_test("alu");
    endtask

    task automatic test_forward();
        mark = errors;
        load_reg(5'd1, $random(seed));
        do_alu(exec_pkg::ALU_ADDU, 5'd1, 5'd0, 5'd2, $random(seed), 1'b1, 1'b0);
        do_alu(exec_pkg::ALU_XOR, 5'd1, 5'd2, 5'd3, '0, 1'b0, 1'b0);
        do_alu(exec_pkg::ALU_SUBU, 5'd1, 5'd3, 5'd4, '0, 1'b0, 1'b0);
        do_alu(exec_pkg::ALU_OR, 5'd2, 5'd4, 5'd5, '0, 1'b0, 1'b0);
        // Two writes to r6 in flight, the younger must win
        load_reg(5'd6, $random(seed));
        load_reg(5'd6, $random(seed));
        do_alu(exec_pkg::ALU_ADDU, 5'd6, 5'd6, 5'd7, '0, 1'b0, 1'b0);
        // MEM/WB over the register file
        load_reg(5'd8, $random(seed));
        load_reg(5'd8, $random(seed));
        load_reg(5'd9, $random(seed));
        do_alu(exec_pkg::ALU_SUBU, 5'd8, 5'd9, 5'd10, '0, 1'b0, 1'b0);
        end_test("forward");
    endtask

    task automatic test_shift();
        exec_pkg::shift_op_t sh;
        exec_pkg::word_t     rnd;
        mark = errors;
        load_reg(5'd8, $random(seed) | 32'h8000_0000);
        load_reg(5'd9, $random(seed));
        load_reg(5'd16, $random(seed) & 32'h7fff_ffff);
        for (int k = 0; k < 3; k++) begin
            sh  = exec_pkg::shift_op_t'(k);
            rnd = $random(seed);
            do_shift(sh, 5'd0, 5'd8, exec_pkg::reg_addr_t'(10 + k), rnd[4:0], 1'b0);
            do_shift(sh, 5'd9, 5'd8, exec_pkg::reg_addr_t'(13 + k), 5'd0, 1'b1);
            do_shift(sh, 5'd9, 5'd16, exec_pkg::reg_addr_t'(17 + k), 5'd0, 1'b1);
        end
        // Extreme amounts on a negative value
        do_shift(exec_pkg::SH_SRA, 5'd0, 5'd8, 5'd20, 5'd31, 1'b0);
        do_shift(exec_pkg::SH_SRA, 5'd0, 5'd8, 5'd21, 5'd0, 1'b0);
        end_test("shift");
    endtask

    task automatic test_move_overflow();
        mark = errors;
        load_reg(5'd1, $random(seed));
        load_reg(5'd2, 32'h0);
        load_reg(5'd3, $random(seed) | 32'h1);
        for (int k = 4; k < 8; k++) begin
            load_reg(exec_pkg::reg_addr_t'(k), $random(seed));
        end
        do_move(exec_pkg::RES_MOVZ, 5'd1, 5'd2, 5'd4);
        do_move(exec_pkg::RES_MOVZ, 5'd1, 5'd3, 5'd5);
        do_move(exec_pkg::RES_MOVN, 5'd1, 5'd3, 5'd6);
        do_move(exec_pkg::RES_MOVN, 5'd1, 5'd2, 5'd7);
        load_reg(5'd10, 32'h7fff_ffff);
        load_reg(5'd11, 32'h1);
        load_reg(5'd12, 32'hdead_beef);
        load_reg(5'd14, 32'h1234_5678);
        load_reg(5'd15, 32'h8000_0000);
        do_alu(exec_pkg::ALU_ADD, 5'd10, 5'd11, 5'd12, '0, 1'b0, 1'b1);
        do_alu(exec_pkg::ALU_ADDU, 5'd10, 5'd11, 5'd13, '0, 1'b0, 1'b1);
        do_alu(exec_pkg::ALU_SUB, 5'd15, 5'd11, 5'd14, '0, 1'b0, 1'b1);
        do_alu(exec_pkg::ALU_ADD, 5'd11, 5'd11, 5'd16, '0, 1'b0, 1'b1);
        // r0 write is dropped, also on the forwarding path
        load_reg(5'd17, $random(seed));
        load_reg(5'd0, 32'h1234);
        do_alu(exec_pkg::ALU_ADDU, 5'd0, 5'd0, 5'd17, '0, 1'b0, 1'b0);
        end_test("move_ovf");
    endtask

    task automatic test_stall();
        exec_pkg::word_t     rnd;
        exec_pkg::reg_addr_t rd;
        exec_pkg::reg_addr_t rs;
        exec_pkg::reg_addr_t rt;
        mark       = errors;
        stall_mode = 1'b1;
        // Each instruction reads the previous two results
        for (int k = 0; k < 24; k++) begin
            rnd = $random(seed);
            rd  = exec_pkg::reg_addr_t'(20 + k % 4);
            rs  = exec_pkg::reg_addr_t'(20 + (k + 3) % 4);
            rt  = exec_pkg::reg_addr_t'(20 + (k + 2) % 4);
            case (k % 3)
                0:       do_alu(exec_pkg::ALU_ADDU, rs, rt, rd, rnd, 1'b1, 1'b0);
                1:       do_alu(exec_pkg::ALU_XOR, rs, rt, rd, '0, 1'b0, 1'b0);
                default: do_shift(exec_pkg::SH_SRA, rs, rt, rd, 5'd0, 1'b1);
            endcase
        end
        stall_mode = 1'b0;
        end_test("stall");
    endtask

    // commit_en must stay low through a stalled cycle
    always @(negedge clk) begin
        if (rst_n && stall && commit_en) begin
            errors++;
            $display("commit_en went high while stall was set at %0t", $time);
        end
    end

    // Each writeback on commit matches the oldest expected write
    always @(negedge clk) begin
        if (rst_n && commit_en) begin
            if (wb_expect.size() == 0) begin
                errors++;
                $display("Writeback to r%0d with no instruction expecting it at %0t",
                         commit.rd_addr, $time);
            end else begin
                if (commit.rd_addr !== wb_expect[0].rd_addr) begin
                    errors++;
                    $display("ERR commit.rd_addr expected %h actual %h",
                             wb_expect[0].rd_addr, commit.rd_addr);
                end
                if (commit.result !== wb_expect[0].result) begin
                    errors++;
                    $display("ERR commit.result expected %h actual %h",
                             wb_expect[0].result, commit.result);
                end
                wb_expect.delete(0);
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        issue      = '0;
        stall      = 1'b0;
        dbg_addr   = '0;
        seed       = 94;
        errors     = 0;
        tests      = 0;
        mark       = 0;
        stall_mode = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_alu();
        test_forward();
        test_shift();
        test_move_overflow();
        test_stall();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(timeout_cycles * clk_period);
        $display("Timeout, run did not finish within %0d cycles", timeout_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
src/exec_pkg.sv
src/gpr.sv
src/forward_unit.sv
src/alu.sv
src/execute_stage.sv
src/exec_pipeline.sv
tb/exec_pipeline_props.sv
tb/tb_exec_pipeline.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_exec_pipeline
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log
FAIL_MSG := Errors found
PASS_MSG := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
